/* src/core_bus_pkg.sv */
`default_nettype none

package core_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // core side requests, valid held until the done pulse
  typedef struct packed {
    addr_t addr;
    logic  valid;
  } ifu_req_t;

  typedef struct packed {
    addr_t      addr;
    logic [3:0] strb;  // unshifted, 0001 / 0011 / 1111
    logic       valid;
  } lsu_rd_req_t;

  typedef struct packed {
    addr_t      addr;
    word_t      data;
    logic [3:0] strb;
    logic       valid;
  } lsu_wr_req_t;

  // axi4 channel payloads
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic [3:0] id;
  } axi_ar_t;

  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic [3:0] id;
  } axi_aw_t;

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  strb;
    logic        last;
  } axi_w_t;

  typedef struct packed {
    logic [63:0] data;
    logic [1:0]  resp;
    logic        last;
    logic [3:0]  id;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
    logic [3:0] id;
  } axi_b_t;

  localparam logic [2:0] size_byte_c = 3'b000;
  localparam logic [2:0] size_half_c = 3'b001;
  localparam logic [2:0] size_word_c = 3'b010;

  localparam logic [1:0] resp_okay_c = 2'b00;

  typedef enum logic [2:0] {
    st_idle     = 3'd0,
    st_if_data  = 3'd1,
    st_ls_addr  = 3'd2,
    st_ls_rdata = 3'd3,
    st_ls_wresp = 3'd4,
    st_clint    = 3'd5
  } bus_state_e;

endpackage

`default_nettype wire

/* src/axi_lane_align.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_lane_align
  import core_bus_pkg::*;
(
  input  wire addr_t       sel_addr_i,
  input  wire [3:0]        sel_strb_i,
  input  wire              sel_is_ifu_i,
  input  wire word_t       wdata_i,
  output axi_ar_t          ar_o,
  output axi_aw_t          aw_o,
  output axi_w_t           w_o,
  input  wire [63:0]       r_data_i,
  output word_t            rdata_o
);

  logic [2:0] size;
  logic [3:0] strb_sh;
  word_t      wdata_sh;

  always_comb begin
    if (sel_is_ifu_i) begin
      size = size_word_c;  // fetches are always full words
    end else begin
      case (sel_strb_i)
        4'b0011: size = size_half_c;
        4'b1111: size = size_word_c;
        default: size = size_byte_c;
      endcase
    end
  end

  // move the store to its byte offset inside the word
  assign wdata_sh = wdata_i << {sel_addr_i[1:0], 3'b000};
  assign strb_sh  = sel_strb_i << sel_addr_i[1:0];

  // single beat, incr
  assign ar_o = '{
    addr:  sel_addr_i,
    len:   8'd0,
    size:  size,
    burst: 2'b01,
    id:    4'd0
  };

  assign aw_o = '{
    addr:  sel_addr_i,
    len:   8'd0,
    size:  size,
    burst: 2'b01,
    id:    4'd0
  };

  // data on both halves, strobe picks the live one
  assign w_o = '{
    data: {wdata_sh, wdata_sh},
    strb: sel_addr_i[2] ? {strb_sh, 4'h0} : {4'h0, strb_sh},
    last: 1'b1
  };

  // lsu does its own byte extraction
  assign rdata_o = sel_addr_i[2] ? r_data_i[63:32] : r_data_i[31:0];

endmodule

`default_nettype wire

/* src/clint_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module clint_timer
  import core_bus_pkg::*;
#(
  parameter addr_t CLINT_BASE = 32'h0200_bff8
) (
  input  wire        clk,
  input  wire        rst,
  input  wire        rd_en_i,
  input  wire addr_t rd_addr_i,
  output logic       rd_valid_o,
  output word_t      rd_data_o
);

  localparam addr_t MTIMEH_ADDR = CLINT_BASE + 32'd4;

  logic [63:0] mtime_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q    <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      mtime_q    <= mtime_q + 64'd1;  // free running
      rd_valid_o <= rd_en_i;
    end
  end

  // value as of the rd_en cycle
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= (rd_addr_i == MTIMEH_ADDR) ? mtime_q[63:32] : mtime_q[31:0];
    end
  end

endmodule

`default_nettype wire

/* src/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter
  import core_bus_pkg::*;
#(
  parameter addr_t CLINT_BASE = 32'h0200_bff8
) (
  input  wire              clk,
  input  wire              rst,
  // core side
  input  wire ifu_req_t    ifu_req_i,
  output logic             ifu_done_o,
  output word_t            ifu_rdata_o,
  input  wire lsu_rd_req_t lsu_rd_i,
  output logic             lsu_rd_done_o,
  output word_t            lsu_rdata_o,
  input  wire lsu_wr_req_t lsu_wr_i,
  output logic             lsu_wr_done_o,
  // axi handshake side
  output logic             m_arvalid_o,
  input  wire              m_arready_i,
  input  wire              m_rvalid_i,
  input  wire              m_r_last_i,
  input  wire [1:0]        m_r_resp_i,
  output logic             m_awvalid_o,
  input  wire              m_awready_i,
  output logic             m_wvalid_o,
  input  wire              m_wready_i,
  input  wire              m_bvalid_i,
  input  wire [1:0]        m_b_resp_i,
  // to the lane aligner
  output addr_t            sel_addr_o,
  output logic [3:0]       sel_strb_o,
  output logic             sel_is_ifu_o,
  input  wire word_t       lane_rdata_i,
  // timer read port
  output logic             clint_rd_en_o,
  output addr_t            clint_rd_addr_o,
  input  wire              clint_rd_valid_i,
  input  wire word_t       clint_rd_data_i
);

  bus_state_e state_q, state_d;
  logic live_q;  // holds the port quiet on the first cycle out of reset
  logic aw_done_q, w_done_q;
  logic ifu_go, lsu_pend, ls_is_wr, ls_is_clint;
  logic aw_all, w_all;

  assign lsu_pend = lsu_rd_i.valid | lsu_wr_i.valid;
  assign ls_is_wr = lsu_wr_i.valid;  // store wins if both are up
  assign ls_is_clint = ~ls_is_wr & lsu_rd_i.valid &
                       ((lsu_rd_i.addr == CLINT_BASE) ||
                        (lsu_rd_i.addr == CLINT_BASE + 32'd4));
  assign ifu_go = (state_q == st_idle) & live_q & ifu_req_i.valid;

  assign m_arvalid_o = ifu_go |
                       ((state_q == st_ls_addr) & lsu_rd_i.valid & ~ls_is_wr & ~ls_is_clint);
  assign m_awvalid_o = (state_q == st_ls_addr) & ls_is_wr & ~aw_done_q;
  assign m_wvalid_o  = (state_q == st_ls_addr) & ls_is_wr & ~w_done_q;

  // aw and w may finish in either order
  assign aw_all = aw_done_q | (m_awvalid_o & m_awready_i);
  assign w_all  = w_done_q | (m_wvalid_o & m_wready_i);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      st_idle: begin
        if (live_q) begin
          if (ifu_req_i.valid) begin
            if (m_arready_i) begin
              state_d = st_if_data;
            end
          end else if (ls_is_clint) begin
            state_d = st_clint;
          end else if (lsu_pend) begin
            state_d = st_ls_addr;
          end
        end
      end
      st_if_data: begin
        if (m_rvalid_i && m_r_last_i) begin
          state_d = lsu_pend ? st_ls_addr : st_idle;  // lsu gets the next turn
        end
      end
      st_ls_addr: begin
        if (ls_is_wr) begin
          if (aw_all && w_all) begin
            state_d = st_ls_wresp;
          end
        end else if (ls_is_clint) begin
          state_d = st_clint;
        end else if (lsu_rd_i.valid) begin
          if (m_arready_i) begin
            state_d = st_ls_rdata;
          end
        end else begin
          state_d = st_idle;
        end
      end
      st_ls_rdata: begin
        if (m_rvalid_i) begin
          state_d = st_idle;
        end
      end
      st_ls_wresp: begin
        if (m_bvalid_i) begin
          state_d = st_idle;
        end
      end
      st_clint: begin
        if (clint_rd_valid_i) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= st_idle;
      live_q    <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      live_q  <= 1'b1;
      if (state_q == st_ls_addr && state_d == st_ls_addr) begin
        aw_done_q <= aw_all;
        w_done_q  <= w_all;
      end else begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end
    end
  end

  // granted request to the lanes
  assign sel_is_ifu_o = ifu_go | (state_q == st_if_data);
  assign sel_addr_o = sel_is_ifu_o ? ifu_req_i.addr :
                      ls_is_wr     ? lsu_wr_i.addr  : lsu_rd_i.addr;
  assign sel_strb_o = sel_is_ifu_o ? 4'hf :
                      ls_is_wr     ? lsu_wr_i.strb : lsu_rd_i.strb;

  // timer sampled on the first st_clint cycle, answer one cycle later
  assign clint_rd_en_o   = (state_q == st_clint) & ~clint_rd_valid_i;
  assign clint_rd_addr_o = lsu_rd_i.addr;

  assign ifu_done_o    = (state_q == st_if_data) & m_rvalid_i & m_r_last_i;
  assign lsu_rd_done_o = ((state_q == st_ls_rdata) & m_rvalid_i) |
                         ((state_q == st_clint) & clint_rd_valid_i);
  assign lsu_wr_done_o = (state_q == st_ls_wresp) & m_bvalid_i;

  assign ifu_rdata_o = lane_rdata_i;
  assign lsu_rdata_o = (state_q == st_clint) ? clint_rd_data_i : lane_rdata_i;

  a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_rvalid_i |-> m_r_resp_i == resp_okay_c);

  a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_bvalid_i |-> m_b_resp_i == resp_okay_c);

  // relies on the core holding its request
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o);

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    m_awvalid_o && !m_awready_i |=> m_awvalid_o);

  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    m_wvalid_o && !m_wready_i |=> m_wvalid_o);

  a_done_excl: assert property (@(posedge clk) disable iff (rst)
    $onehot0({ifu_done_o, lsu_rd_done_o, lsu_wr_done_o}));

endmodule

`default_nettype wire

/* src/core_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module core_bus
  import core_bus_pkg::*;
#(
  parameter addr_t CLINT_BASE = 32'h0200_bff8
) (
  input  wire              clk,
  input  wire              rst,
  // ifu
  input  wire ifu_req_t    ifu_req_i,
  output logic             ifu_done_o,
  output word_t            ifu_rdata_o,
  // lsu
  input  wire lsu_rd_req_t lsu_rd_i,
  output logic             lsu_rd_done_o,
  output word_t            lsu_rdata_o,
  input  wire lsu_wr_req_t lsu_wr_i,
  output logic             lsu_wr_done_o,
  // axi4 master
  output axi_ar_t          m_ar_o,
  output logic             m_arvalid_o,
  input  wire              m_arready_i,
  input  wire axi_r_t      m_r_i,
  input  wire              m_rvalid_i,
  output logic             m_rready_o,
  output axi_aw_t          m_aw_o,
  output logic             m_awvalid_o,
  input  wire              m_awready_i,
  output axi_w_t           m_w_o,
  output logic             m_wvalid_o,
  input  wire              m_wready_i,
  input  wire axi_b_t      m_b_i,
  input  wire              m_bvalid_i,
  output logic             m_bready_o
);

  addr_t      sel_addr;
  logic [3:0] sel_strb;
  logic       sel_is_ifu;
  word_t      lane_rdata;
  logic       clint_rd_en;
  addr_t      clint_rd_addr;
  logic       clint_rd_valid;
  word_t      clint_rd_data;

  assign m_rready_o = 1'b1;  // one request in flight, always room
  assign m_bready_o = 1'b1;

  bus_arbiter #(
    .CLINT_BASE(CLINT_BASE)
  ) u_arbiter (
    .clk              (clk),
    .rst              (rst),
    .ifu_req_i        (ifu_req_i),
    .ifu_done_o       (ifu_done_o),
    .ifu_rdata_o      (ifu_rdata_o),
    .lsu_rd_i         (lsu_rd_i),
    .lsu_rd_done_o    (lsu_rd_done_o),
    .lsu_rdata_o      (lsu_rdata_o),
    .lsu_wr_i         (lsu_wr_i),
    .lsu_wr_done_o    (lsu_wr_done_o),
    .m_arvalid_o      (m_arvalid_o),
    .m_arready_i      (m_arready_i),
    .m_rvalid_i       (m_rvalid_i),
    .m_r_last_i       (m_r_i.last),
    .m_r_resp_i       (m_r_i.resp),
    .m_awvalid_o      (m_awvalid_o),
    .m_awready_i      (m_awready_i),
    .m_wvalid_o       (m_wvalid_o),
    .m_wready_i       (m_wready_i),
    .m_bvalid_i       (m_bvalid_i),
    .m_b_resp_i       (m_b_i.resp),
    .sel_addr_o       (sel_addr),
    .sel_strb_o       (sel_strb),
    .sel_is_ifu_o     (sel_is_ifu),
    .lane_rdata_i     (lane_rdata),
    .clint_rd_en_o    (clint_rd_en),
    .clint_rd_addr_o  (clint_rd_addr),
    .clint_rd_valid_i (clint_rd_valid),
    .clint_rd_data_i  (clint_rd_data)
  );

  axi_lane_align u_lane (
    .sel_addr_i   (sel_addr),
    .sel_strb_i   (sel_strb),
    .sel_is_ifu_i (sel_is_ifu),
    .wdata_i      (lsu_wr_i.data),
    .ar_o         (m_ar_o),
    .aw_o         (m_aw_o),
    .w_o          (m_w_o),
    .r_data_i     (m_r_i.data),
    .rdata_o      (lane_rdata)
  );

  clint_timer #(
    .CLINT_BASE(CLINT_BASE)
  ) u_clint (
    .clk        (clk),
    .rst        (rst),
    .rd_en_i    (clint_rd_en),
    .rd_addr_i  (clint_rd_addr),
    .rd_valid_o (clint_rd_valid),
    .rd_data_o  (clint_rd_data)
  );

endmodule

`default_nettype wire

/* test/axi_slave_model.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_slave_model
  import core_bus_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  // a high stall holds that channel off for the cycle
  input  wire          ar_stall_i,
  input  wire          aw_stall_i,
  input  wire          w_stall_i,
  input  wire          resp_stall_i,
  input  wire axi_ar_t ar_i,
  input  wire          arvalid_i,
  output logic         arready_o,
  output axi_r_t       r_o,
  output logic         rvalid_o,
  input  wire          rready_i,
  input  wire axi_aw_t aw_i,
  input  wire          awvalid_i,
  output logic         awready_o,
  input  wire axi_w_t  w_i,
  input  wire          wvalid_i,
  output logic         wready_o,
  output axi_b_t       b_o,
  output logic         bvalid_o,
  input  wire          bready_i
);

  logic [63:0] mem [0:1023];  // filled by the testbench
  logic        rd_busy_q = 1'b0;
  logic        rvalid_q = 1'b0;
  addr_t       rd_addr_q = '0;
  logic [63:0] rdata_q = '0;
  logic        aw_got_q = 1'b0;
  logic        w_got_q = 1'b0;
  logic        bvalid_q = 1'b0;
  addr_t       wr_addr_q = '0;
  logic [63:0] wdata_q = '0;
  logic [7:0]  wstrb_q = '0;

  function automatic logic [63:0] merge_bytes(input logic [63:0] old,
                                              input logic [63:0] data,
                                              input logic [7:0] strb);
    logic [63:0] res;
    res = old;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign arready_o = ~ar_stall_i & ~rd_busy_q;  // one read at a time
  assign awready_o = ~aw_stall_i & ~aw_got_q;
  assign wready_o  = ~w_stall_i & ~w_got_q;
  assign rvalid_o  = rvalid_q;
  assign bvalid_o  = bvalid_q;
  assign r_o = '{data: rdata_q, resp: resp_okay_c, last: 1'b1, id: 4'd0};
  assign b_o = '{resp: resp_okay_c, id: 4'd0};

  always @(posedge clk) begin
    if (rst) begin
      rd_busy_q <= 1'b0;
      rvalid_q  <= 1'b0;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      if (arvalid_i && arready_o) begin
        rd_busy_q <= 1'b1;
        rd_addr_q <= ar_i.addr;
      end
      if (rvalid_q && rready_i) begin
        rvalid_q  <= 1'b0;
        rd_busy_q <= 1'b0;
      end else if (rd_busy_q && !rvalid_q && !resp_stall_i) begin
        rvalid_q <= 1'b1;
        rdata_q  <= mem[rd_addr_q[12:3]];
      end
      if (awvalid_i && awready_o) begin
        aw_got_q  <= 1'b1;
        wr_addr_q <= aw_i.addr;
      end
      if (wvalid_i && wready_o) begin
        w_got_q <= 1'b1;
        wdata_q <= w_i.data;
        wstrb_q <= w_i.strb;
      end
      if (bvalid_q && bready_i) begin
        bvalid_q <= 1'b0;
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
      end else if (aw_got_q && w_got_q && !bvalid_q && !resp_stall_i) begin
        bvalid_q <= 1'b1;
        mem[wr_addr_q[12:3]] <= merge_bytes(mem[wr_addr_q[12:3]], wdata_q, wstrb_q);
      end
    end
  end

endmodule

`default_nettype wire

/* test/tb_core_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_core_bus
  import core_bus_pkg::*;
();

  localparam addr_t CLINT_BASE = 32'h0200_bff8;
  localparam int    TIMEOUT = 2000;

  logic        clk = 1'b0;
  logic        rst;
  ifu_req_t    ifu_req;
  logic        ifu_done;
  word_t       ifu_rdata;
  lsu_rd_req_t lsu_rd;
  logic        lsu_rd_done;
  word_t       lsu_rdata;
  lsu_wr_req_t lsu_wr;
  logic        lsu_wr_done;
  axi_ar_t     m_ar;
  axi_aw_t     m_aw;
  axi_w_t      m_w;
  axi_r_t      m_r;
  axi_b_t      m_b;
  logic        m_arvalid, m_arready, m_rvalid, m_rready;
  logic        m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
  logic        ar_stall, aw_stall, w_stall, resp_stall;
  logic [3:0]  stall_level = 4'd2;  // stall odds in sixteenths

  logic [31:0] stim_rng = 32'h9153;
  logic [31:0] stall_rng = 32'h9153;
  word_t       shadow [0:2047];
  word_t       ifu_exp [$];
  logic [32:0] lsu_exp [$];  // bit 32 set when the value is checked
  word_t       lsu_last;
  int          err_cnt = 0;
  int          timeout_cnt = 0;
  int          cyc = 0;
  int          ifu_done_cyc = 0;
  int          lsu_done_cyc = 0;
  int          ar_valid_cycles = 0;
  int          aw_hs = 0;
  int          w_hs = 0;
  axi_ar_t     ar_seen, ar_prev;
  axi_aw_t     aw_seen, aw_prev;
  axi_w_t      w_seen, w_prev;
  logic        ar_wait = 1'b0;
  logic        aw_wait = 1'b0;
  logic        w_wait = 1'b0;
  logic        rst_prev = 1'b1;  // rst as seen one negedge earlier

  always #2 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  core_bus #(.CLINT_BASE(CLINT_BASE)) u_dut (
    .clk(clk), .rst(rst),
    .ifu_req_i(ifu_req), .ifu_done_o(ifu_done), .ifu_rdata_o(ifu_rdata),
    .lsu_rd_i(lsu_rd), .lsu_rd_done_o(lsu_rd_done), .lsu_rdata_o(lsu_rdata),
    .lsu_wr_i(lsu_wr), .lsu_wr_done_o(lsu_wr_done),
    .m_ar_o(m_ar), .m_arvalid_o(m_arvalid), .m_arready_i(m_arready),
    .m_r_i(m_r), .m_rvalid_i(m_rvalid), .m_rready_o(m_rready),
    .m_aw_o(m_aw), .m_awvalid_o(m_awvalid), .m_awready_i(m_awready),
    .m_w_o(m_w), .m_wvalid_o(m_wvalid), .m_wready_i(m_wready),
    .m_b_i(m_b), .m_bvalid_i(m_bvalid), .m_bready_o(m_bready)
  );

  axi_slave_model u_slave (
    .clk(clk), .rst(rst),
    .ar_stall_i(ar_stall), .aw_stall_i(aw_stall), .w_stall_i(w_stall),
    .resp_stall_i(resp_stall),
    .ar_i(m_ar), .arvalid_i(m_arvalid), .arready_o(m_arready),
    .r_o(m_r), .rvalid_o(m_rvalid), .rready_i(m_rready),
    .aw_i(m_aw), .awvalid_i(m_awvalid), .awready_o(m_awready),
    .w_i(m_w), .wvalid_i(m_wvalid), .wready_o(m_wready),
    .b_o(m_b), .bvalid_o(m_bvalid), .bready_i(m_bready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t ref_init(input addr_t a);
    return (a * 32'h0001_0193) ^ 32'hc3a5_5a3c ^ {a[15:0], a[31:16]};
  endfunction

  function automatic word_t ref_load(input addr_t a);
    return shadow[a[12:2]];
  endfunction

  function automatic void ref_store(input addr_t a, input word_t d, input logic [3:0] strb);
    word_t w;
    w = shadow[a[12:2]];
    for (int i = 0; i < 4; i++) begin
      if (strb[i] && (i + a[1:0]) < 4) begin
        w[8*(i + a[1:0]) +: 8] = d[8*i +: 8];
      end
    end
    shadow[a[12:2]] = w;
  endfunction

  // byte lane of each strobe bit within the 64-bit beat
  function automatic logic [7:0] exp_wstrb(input addr_t a, input logic [3:0] strb);
    logic [7:0] s;
    s = '0;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        s[a[2:0] + i] = 1'b1;
      end
    end
    return s;
  endfunction

  function automatic logic [2:0] exp_size(input logic [3:0] strb);
    if (strb == 4'b0001) return size_byte_c;
    if (strb == 4'b0011) return size_half_c;
    return size_word_c;
  endfunction

  task automatic check(input string name, input logic [127:0] expected,
                       input logic [127:0] actual);
    if (expected !== actual) begin
      err_cnt++;
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic end_run();
    $display("errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    timeout_cnt++;
    $display("TIMEOUT: %s saw no done pulse within %0d cycles", what, TIMEOUT);
    end_run();
  endtask

  // stalls change 1 ns after the edge like every other input
  always @(posedge clk) begin
    #1;
    stall_rng  = lcg_next(stall_rng);
    ar_stall   = stall_rng[31:28] < stall_level;
    aw_stall   = stall_rng[27:24] < stall_level;
    w_stall    = stall_rng[23:20] < stall_level;
    resp_stall = stall_rng[19:16] < stall_level;
  end

  // done pulses against the expected queues
  always @(negedge clk) begin
    logic [32:0] e;
    if (!rst) begin
      if (ifu_done) begin
        ifu_done_cyc = cyc;
        if (ifu_exp.size() == 0) begin
          err_cnt++;
          $display("ifu done pulse arrived with no fetch outstanding");
        end else begin
          check("ifu_rdata", ifu_exp.pop_front(), ifu_rdata);
        end
      end
      if (lsu_rd_done) begin
        lsu_done_cyc = cyc;
        lsu_last = lsu_rdata;
        if (lsu_exp.size() == 0) begin
          err_cnt++;
          $display("lsu load done pulse arrived with no load outstanding");
        end else begin
          e = lsu_exp.pop_front();
          if (e[32]) check("lsu_rdata", e[31:0], lsu_rdata);
        end
      end
      if (lsu_wr_done) lsu_done_cyc = cyc;
    end
  end

  // port rules: valid holds with a stable payload until ready
  always @(negedge clk) begin
    // quiet in reset and on the first cycle after it
    if (rst || rst_prev) begin
      check("quiet_after_reset", 0,
            {m_arvalid, m_awvalid, m_wvalid, ifu_done, lsu_rd_done, lsu_wr_done});
    end else begin
      check("rready_tied", 1, m_rready);
      check("bready_tied", 1, m_bready);
    end
    if (!rst) begin
      if (ar_wait) begin
        check("arvalid_hold", 1, m_arvalid);
        check("ar_stable", ar_prev, m_ar);
      end
      if (aw_wait) begin
        check("awvalid_hold", 1, m_awvalid);
        check("aw_stable", aw_prev, m_aw);
      end
      if (w_wait) begin
        check("wvalid_hold", 1, m_wvalid);
        check("w_stable", w_prev, m_w);
      end
      if (m_arvalid) ar_valid_cycles++;
      if (m_arvalid && m_arready) ar_seen = m_ar;
      if (m_awvalid && m_awready) begin
        aw_hs++;
        aw_seen = m_aw;
      end
      if (m_wvalid && m_wready) begin
        w_hs++;
        w_seen = m_w;
      end
    end
    ar_wait = !rst && m_arvalid && !m_arready;
    aw_wait = !rst && m_awvalid && !m_awready;
    w_wait  = !rst && m_wvalid && !m_wready;
    ar_prev = m_ar;
    aw_prev = m_aw;
    w_prev  = m_w;
    rst_prev = rst;
  end

  task automatic ifu_fetch(input addr_t a);
    int n;
    ifu_exp.push_back(ref_load(a));
    ifu_req.addr  = a;
    ifu_req.valid = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ifu_done && n < TIMEOUT);
    if (!ifu_done) begin
      abort_on_timeout("ifu fetch");
    end else begin
      check("ifu_arsize", size_word_c, ar_seen.size);
      check("ifu_arlen", 0, ar_seen.len);
      check("ifu_araddr", a, ar_seen.addr);
      @(posedge clk);
      #1;
      ifu_req.valid = 1'b0;
    end
  endtask

  task automatic lsu_load(input addr_t a, input logic [3:0] strb, input logic chk,
                          input word_t exp);
    int n;
    lsu_exp.push_back({chk, exp});
    lsu_rd.addr  = a;
    lsu_rd.strb  = strb;
    lsu_rd.valid = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!lsu_rd_done && n < TIMEOUT);
    if (!lsu_rd_done) begin
      abort_on_timeout("lsu load");
    end else begin
      @(posedge clk);
      #1;
      lsu_rd.valid = 1'b0;
    end
  endtask

  task automatic lsu_store(input addr_t a, input word_t d, input logic [3:0] strb);
    int n;
    int aw0;
    int w0;
    aw0 = aw_hs;
    w0  = w_hs;
    lsu_wr.addr  = a;
    lsu_wr.data  = d;
    lsu_wr.strb  = strb;
    lsu_wr.valid = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!lsu_wr_done && n < TIMEOUT);
    if (!lsu_wr_done) begin
      abort_on_timeout("lsu store");
    end else begin
      check("st_aw_count", aw0 + 1, aw_hs);
      check("st_w_count", w0 + 1, w_hs);
      check("st_awaddr", a, aw_seen.addr);
      check("st_awsize", exp_size(strb), aw_seen.size);
      check("st_wstrb", exp_wstrb(a, strb), w_seen.strb);
      ref_store(a, d, strb);
      @(posedge clk);
      #1;
      lsu_wr.valid = 1'b0;
    end
  endtask

  task automatic random_fetches(input int count);
    for (int i = 0; i < count; i++) begin
      stim_rng = lcg_next(stim_rng);
      ifu_fetch((stim_rng >> 8) & 32'h1ffc);
    end
  endtask

  task automatic random_store_loads(input int count);
    logic [31:0] r;
    addr_t       a;
    logic [3:0]  strb;
    for (int i = 0; i < count; i++) begin
      stim_rng = lcg_next(stim_rng);
      r = stim_rng;
      a = (r >> 8) & 32'h1ffc;
      case (r[31:30])
        2'd0: begin
          strb    = 4'b0001;
          a[1:0]  = r[29:28];
        end
        2'd1: begin
          strb = 4'b0011;
          a[1] = r[29];
        end
        default: strb = 4'b1111;
      endcase
      stim_rng = lcg_next(stim_rng);
      lsu_store(a, stim_rng, strb);
      lsu_load({a[31:2], 2'b00}, 4'hf, 1'b1, ref_load(a));
    end
  endtask

  task automatic set_stall(input logic [3:0] level);
    @(negedge clk);
    stall_level = level;
    @(posedge clk);
    #1;
  endtask

  initial begin
    addr_t fa;
    addr_t la;
    word_t v0;
    int    c0;
    int    c1;
    int    ar0;
    ifu_req = '0;
    lsu_rd  = '0;
    lsu_wr  = '0;
    ar_stall   = 1'b0;
    aw_stall   = 1'b0;
    w_stall    = 1'b0;
    resp_stall = 1'b0;
    rst = 1'b1;
    for (int i = 0; i < 1024; i++) begin
      shadow[2*i]     = ref_init(addr_t'(i * 8));
      shadow[2*i + 1] = ref_init(addr_t'(i * 8 + 4));
      u_slave.mem[i]  = {ref_init(addr_t'(i * 8 + 4)), ref_init(addr_t'(i * 8))};
    end
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    random_fetches(12);
    random_store_loads(12);

    // ifu and lsu raised together, ifu must finish first
    stim_rng = lcg_next(stim_rng);
    fa = (stim_rng >> 8) & 32'h1ffc;
    la = (stim_rng >> 4) & 32'h1ffc;
    fork
      ifu_fetch(fa);
      lsu_load(la, 4'hf, 1'b1, ref_load(la));
    join
    check("arb_ifu_first_ld", 1, ifu_done_cyc < lsu_done_cyc);
    stim_rng = lcg_next(stim_rng);
    fork
      ifu_fetch(fa);
      lsu_store(la, stim_rng, 4'hf);
    join
    check("arb_ifu_first_st", 1, ifu_done_cyc < lsu_done_cyc);

    // timer reads, value step equals request cycle step
    ar0 = ar_valid_cycles;
    c0 = cyc;
    lsu_load(CLINT_BASE, 4'hf, 1'b0, '0);
    v0 = lsu_last;
    repeat (7) @(posedge clk);
    #1;
    c1 = cyc;
    lsu_load(CLINT_BASE, 4'hf, 1'b1, v0 + word_t'(c1 - c0));
    lsu_load(CLINT_BASE + 32'd4, 4'hf, 1'b1, 32'd0);
    check("clint_no_ar", ar0, ar_valid_cycles);

    set_stall(4'd12);
    random_fetches(16);
    random_store_loads(16);
    end_run();
  end

endmodule

`default_nettype wire

/* Bender.yml */
package:
  name: core_bus

sources:
  - src/core_bus_pkg.sv
  - src/axi_lane_align.sv
  - src/clint_timer.sv
  - src/bus_arbiter.sv
  - src/core_bus.sv
  - target: test
    files:
      - test/axi_slave_model.sv
      - test/tb_core_bus.sv

/* core_bus.f */
src/core_bus_pkg.sv
src/axi_lane_align.sv
src/clint_timer.sv
src/bus_arbiter.sv
src/core_bus.sv
test/axi_slave_model.sv
test/tb_core_bus.sv
